//--- verilog/decode_pkg.sv
package decode_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [7:0]  alu_op_t;
	typedef logic [2:0]  alu_sel_t;
	typedef logic [3:0]  br_kind_t;

	localparam opcode_t OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03;
	localparam opcode_t OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07;
	localparam opcode_t OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b;
	localparam opcode_t OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f;
	localparam opcode_t OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24;
	localparam opcode_t OP_LHU     = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b;

	localparam funct_t FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03, FN_SLLV = 6'h04;
	localparam funct_t FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR   = 6'h08, FN_JALR = 6'h09;
	localparam funct_t FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR  = 6'h27;
	localparam funct_t FN_SLT  = 6'h2a, FN_SLTU = 6'h2b;

	// REGIMM selects on the rt field
	localparam reg_addr_t RT_BLTZ = 5'h00, RT_BGEZ = 5'h01, RT_BLTZAL = 5'h10, RT_BGEZAL = 5'h11;

	localparam alu_op_t ALU_NOP  = 8'h00, ALU_OR   = 8'h01, ALU_AND  = 8'h02, ALU_XOR  = 8'h03;
	localparam alu_op_t ALU_NOR  = 8'h04, ALU_SLL  = 8'h05, ALU_SRL  = 8'h06, ALU_SRA  = 8'h07;
	localparam alu_op_t ALU_SLT  = 8'h10, ALU_SLTU = 8'h11, ALU_ADD  = 8'h12, ALU_ADDU = 8'h13;
	localparam alu_op_t ALU_SUB  = 8'h14, ALU_SUBU = 8'h15;
	localparam alu_op_t ALU_J    = 8'h20, ALU_JAL  = 8'h21, ALU_JR   = 8'h22, ALU_JALR = 8'h23;
	localparam alu_op_t ALU_BEQ  = 8'h24, ALU_BNE  = 8'h25, ALU_BGTZ = 8'h26, ALU_BLEZ = 8'h27;
	localparam alu_op_t ALU_BGEZ = 8'h28, ALU_BLTZ = 8'h29, ALU_BGEZAL = 8'h2a, ALU_BLTZAL = 8'h2b;
	localparam alu_op_t ALU_LB   = 8'h30, ALU_LBU  = 8'h31, ALU_LH   = 8'h32, ALU_LHU  = 8'h33;
	localparam alu_op_t ALU_LW   = 8'h34, ALU_SB   = 8'h38, ALU_SH   = 8'h39, ALU_SW   = 8'h3a;

	localparam alu_sel_t SEL_NOP = 3'd0, SEL_LOGIC = 3'd1, SEL_SHIFT = 3'd2;
	localparam alu_sel_t SEL_ARITH = 3'd3, SEL_JB = 3'd4, SEL_LS = 3'd5;

	localparam br_kind_t BR_NONE = 4'd0, BR_JUMP = 4'd1, BR_JREG = 4'd2, BR_EQ = 4'd3;
	localparam br_kind_t BR_NE = 4'd4, BR_GTZ = 4'd5, BR_LEZ = 4'd6, BR_GEZ = 4'd7, BR_LTZ = 4'd8;

	localparam reg_addr_t LINK_REG   = 5'd31;
	localparam word_t     INST_BYTES = 32'd4;

endpackage

//--- verilog/stage_ifs.sv
interface decode_ctrl_if;
	import decode_pkg::*;

	alu_op_t   aluop;
	alu_sel_t  alusel;
	logic      wreg;
	reg_addr_t wraddr;
	logic      r1read;
	reg_addr_t r1addr;
	logic      r2read;
	reg_addr_t r2addr;
	word_t     imm;
	br_kind_t  brkind;

	modport dec (output aluop, alusel, wreg, wraddr, r1read, r1addr, r2read, r2addr, imm, brkind);
	modport sink (input aluop, alusel, wreg, wraddr, r1read, r1addr, r2read, r2addr, imm, brkind);

endinterface

// Result of a later stage, seen by decode
interface fwd_src_if;
	import decode_pkg::*;

	alu_op_t   aluop;
	logic      wreg;
	reg_addr_t wraddr;
	word_t     wrdata;

	modport sink (input aluop, wreg, wraddr, wrdata);

endinterface

//--- verilog/if_id_reg.sv
module if_id_reg (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_stall,
	input  decode_pkg::word_t  i_pc,
	input  decode_pkg::inst_t  i_inst,
	output decode_pkg::word_t  o_pc,
	output decode_pkg::inst_t  o_inst
);
	import decode_pkg::*;

	always_ff @(posedge clk) begin
		if (rst) begin
			o_pc   <= '0;
			o_inst <= '0;  // Zero word decodes as nop
		end else if (!i_stall) begin
			o_pc   <= i_pc;
			o_inst <= i_inst;
		end
	end

endmodule

//--- verilog/inst_decoder.sv
module inst_decoder (
	input  decode_pkg::inst_t i_inst,
	decode_ctrl_if.dec        ctrl
);
	import decode_pkg::*;

	opcode_t   op;
	funct_t    funct;
	reg_addr_t rs, rt, rd, sa;
	word_t     zeimm, seimm, luimm, saimm;
	alu_op_t   sp_op;
	alu_sel_t  sp_sel;
	logic      fn_shift_imm, fn_jump, sp_valid;

	assign op    = i_inst[31:26];
	assign rs    = i_inst[25:21];
	assign rt    = i_inst[20:16];
	assign rd    = i_inst[15:11];
	assign sa    = i_inst[10:6];
	assign funct = i_inst[5:0];

	assign zeimm = {16'h0000, i_inst[15:0]};
	assign seimm = {{16{i_inst[15]}}, i_inst[15:0]};
	assign luimm = {i_inst[15:0], 16'h0000};
	assign saimm = {27'd0, sa};

	// SPECIAL function map
	always_comb begin
		case (funct)
			FN_OR:   {sp_op, sp_sel} = {ALU_OR, SEL_LOGIC};
			FN_AND:  {sp_op, sp_sel} = {ALU_AND, SEL_LOGIC};
			FN_XOR:  {sp_op, sp_sel} = {ALU_XOR, SEL_LOGIC};
			FN_NOR:  {sp_op, sp_sel} = {ALU_NOR, SEL_LOGIC};
			FN_SLL, FN_SLLV: {sp_op, sp_sel} = {ALU_SLL, SEL_SHIFT};
			FN_SRL, FN_SRLV: {sp_op, sp_sel} = {ALU_SRL, SEL_SHIFT};
			FN_SRA, FN_SRAV: {sp_op, sp_sel} = {ALU_SRA, SEL_SHIFT};
			FN_SLT:  {sp_op, sp_sel} = {ALU_SLT, SEL_ARITH};
			FN_SLTU: {sp_op, sp_sel} = {ALU_SLTU, SEL_ARITH};
			FN_ADD:  {sp_op, sp_sel} = {ALU_ADD, SEL_ARITH};
			FN_ADDU: {sp_op, sp_sel} = {ALU_ADDU, SEL_ARITH};
			FN_SUB:  {sp_op, sp_sel} = {ALU_SUB, SEL_ARITH};
			FN_SUBU: {sp_op, sp_sel} = {ALU_SUBU, SEL_ARITH};
			FN_JR:   {sp_op, sp_sel} = {ALU_JR, SEL_JB};
			FN_JALR: {sp_op, sp_sel} = {ALU_JALR, SEL_JB};
			default: {sp_op, sp_sel} = {ALU_NOP, SEL_NOP};
		endcase
	end

	assign fn_shift_imm = funct inside {FN_SLL, FN_SRL, FN_SRA};
	assign fn_jump      = funct inside {FN_JR, FN_JALR};
	// Shift into r0 (incl. the zero word) is a nop
	assign sp_valid = (sp_op != ALU_NOP) && (fn_shift_imm ? (rs == '0 && rd != '0) : (sa == '0));

	always_comb begin
		ctrl.aluop  = ALU_NOP;
		ctrl.alusel = SEL_NOP;
		ctrl.wreg   = 1'b0;
		ctrl.wraddr = rd;
		ctrl.r1read = 1'b0;
		ctrl.r1addr = rs;
		ctrl.r2read = 1'b0;
		ctrl.r2addr = rt;
		ctrl.imm    = '0;
		ctrl.brkind = BR_NONE;
		case (op)
			OP_SPECIAL: if (sp_valid) begin
				{ctrl.aluop, ctrl.alusel} = {sp_op, sp_sel};
				ctrl.wreg   = (funct != FN_JR);
				ctrl.r1read = !fn_shift_imm;
				ctrl.r2read = !fn_jump;
				if (fn_shift_imm)
					ctrl.imm = saimm;
				if (fn_jump)
					ctrl.brkind = BR_JREG;
			end
			OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
				case (op)
					OP_ANDI: ctrl.aluop = ALU_AND;
					OP_XORI: ctrl.aluop = ALU_XOR;
					default: ctrl.aluop = ALU_OR;  // ORI and LUI
				endcase
				{ctrl.alusel, ctrl.wreg, ctrl.wraddr, ctrl.r1read} = {SEL_LOGIC, 1'b1, rt, 1'b1};
				ctrl.imm = (op == OP_LUI) ? luimm : zeimm;
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				case (op)
					OP_ADDI:  ctrl.aluop = ALU_ADD;
					OP_ADDIU: ctrl.aluop = ALU_ADDU;
					OP_SLTI:  ctrl.aluop = ALU_SLT;
					default:  ctrl.aluop = ALU_SLTU;
				endcase
				{ctrl.alusel, ctrl.wreg, ctrl.wraddr, ctrl.r1read} = {SEL_ARITH, 1'b1, rt, 1'b1};
				ctrl.imm = seimm;
			end
			OP_J, OP_JAL: begin
				ctrl.aluop  = (op == OP_JAL) ? ALU_JAL : ALU_J;
				ctrl.alusel = SEL_JB;
				ctrl.wreg   = (op == OP_JAL);
				ctrl.wraddr = LINK_REG;
				ctrl.brkind = BR_JUMP;
			end
			OP_BEQ: {ctrl.aluop, ctrl.alusel, ctrl.r1read, ctrl.r2read, ctrl.brkind} =
				{ALU_BEQ, SEL_JB, 1'b1, 1'b1, BR_EQ};
			OP_BNE: {ctrl.aluop, ctrl.alusel, ctrl.r1read, ctrl.r2read, ctrl.brkind} =
				{ALU_BNE, SEL_JB, 1'b1, 1'b1, BR_NE};
			OP_BGTZ: {ctrl.aluop, ctrl.alusel, ctrl.r1read, ctrl.brkind} = {ALU_BGTZ, SEL_JB, 1'b1, BR_GTZ};
			OP_BLEZ: {ctrl.aluop, ctrl.alusel, ctrl.r1read, ctrl.brkind} = {ALU_BLEZ, SEL_JB, 1'b1, BR_LEZ};
			OP_REGIMM: if (rt inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL}) begin
				case (rt)
					RT_BLTZ:   ctrl.aluop = ALU_BLTZ;
					RT_BGEZ:   ctrl.aluop = ALU_BGEZ;
					RT_BLTZAL: ctrl.aluop = ALU_BLTZAL;
					default:   ctrl.aluop = ALU_BGEZAL;
				endcase
				ctrl.alusel = SEL_JB;
				ctrl.r1read = 1'b1;
				ctrl.wreg   = rt[4];  // Linking forms
				ctrl.wraddr = LINK_REG;
				ctrl.brkind = rt[0] ? BR_GEZ : BR_LTZ;
			end
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
				case (op)
					OP_LB:   ctrl.aluop = ALU_LB;
					OP_LBU:  ctrl.aluop = ALU_LBU;
					OP_LH:   ctrl.aluop = ALU_LH;
					OP_LHU:  ctrl.aluop = ALU_LHU;
					default: ctrl.aluop = ALU_LW;
				endcase
				{ctrl.alusel, ctrl.wreg, ctrl.wraddr, ctrl.r1read} = {SEL_LS, 1'b1, rt, 1'b1};
				ctrl.imm = seimm;  // address offset
			end
			OP_SB, OP_SH, OP_SW: begin
				case (op)
					OP_SB:   ctrl.aluop = ALU_SB;
					OP_SH:   ctrl.aluop = ALU_SH;
					default: ctrl.aluop = ALU_SW;
				endcase
				{ctrl.alusel, ctrl.r1read, ctrl.r2read} = {SEL_LS, 1'b1, 1'b1};
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/operand_forward.sv
module operand_forward (
	input  decode_pkg::word_t     i_r1data,
	input  decode_pkg::word_t     i_r2data,
	decode_ctrl_if.sink           ctrl,
	fwd_src_if.sink               ex,
	fwd_src_if.sink               mem,
	output logic                  o_r1read,
	output logic                  o_r2read,
	output decode_pkg::reg_addr_t o_r1addr,
	output decode_pkg::reg_addr_t o_r2addr,
	output decode_pkg::word_t     o_opr1,
	output decode_pkg::word_t     o_opr2,
	output logic                  o_stall
);
	import decode_pkg::*;

	// EX beats MEM beats register file
	function automatic word_t pick(input logic rd_en, input reg_addr_t addr, input word_t rf);
		if (!rd_en)
			return ctrl.imm;
		if (ex.wreg && ex.wraddr == addr)
			return ex.wrdata;
		if (mem.wreg && mem.wraddr == addr)
			return mem.wrdata;
		return rf;
	endfunction

	function automatic logic is_load(input alu_op_t op);
		return op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW};
	endfunction

	assign o_r1read = ctrl.r1read;
	assign o_r2read = ctrl.r2read;
	assign o_r1addr = ctrl.r1addr;
	assign o_r2addr = ctrl.r2addr;

	always_comb begin
		o_opr1 = pick(ctrl.r1read, ctrl.r1addr, i_r1data);
		o_opr2 = pick(ctrl.r2read, ctrl.r2addr, i_r2data);
	end

	// Hold decode until load data is available
	assign o_stall = (is_load(ex.aluop) && (ex.wraddr == ctrl.r1addr || ex.wraddr == ctrl.r2addr))
		|| (is_load(mem.aluop) && (mem.wraddr == ctrl.r1addr || mem.wraddr == ctrl.r2addr));

endmodule

//--- verilog/branch_resolve.sv
module branch_resolve (
	input  decode_pkg::word_t i_pc,
	input  decode_pkg::inst_t i_inst,
	input  decode_pkg::word_t i_opr1,
	input  decode_pkg::word_t i_opr2,
	decode_ctrl_if.sink       ctrl,
	output logic              o_bflag,
	output decode_pkg::word_t o_baddr,
	output decode_pkg::word_t o_linkaddr
);
	import decode_pkg::*;

	word_t pcp4, pcp8, bofs, target;
	logic  link;

	assign pcp4 = i_pc + INST_BYTES;
	assign pcp8 = pcp4 + INST_BYTES;  // past the delay slot
	assign bofs = {{14{i_inst[15]}}, i_inst[15:0], 2'b00};

	always_comb begin
		case (ctrl.brkind)
			BR_JUMP, BR_JREG: o_bflag = 1'b1;
			BR_EQ:   o_bflag = (i_opr1 == i_opr2);
			BR_NE:   o_bflag = (i_opr1 != i_opr2);
			BR_GTZ:  o_bflag = !i_opr1[31] && i_opr1 != '0;
			BR_LEZ:  o_bflag = i_opr1[31] || i_opr1 == '0;
			BR_GEZ:  o_bflag = !i_opr1[31];
			BR_LTZ:  o_bflag = i_opr1[31];
			default: o_bflag = 1'b0;
		endcase
	end

	always_comb begin
		case (ctrl.brkind)
			BR_JUMP: target = {pcp4[31:28], i_inst[25:0], 2'b00};
			BR_JREG: target = i_opr1;
			default: target = pcp4 + bofs;
		endcase
	end

	assign o_baddr    = o_bflag ? target : '0;
	assign link       = ctrl.aluop inside {ALU_JAL, ALU_JALR, ALU_BGEZAL, ALU_BLTZAL};
	assign o_linkaddr = link ? pcp8 : '0;

endmodule

//--- verilog/id_ex_reg.sv
module id_ex_reg (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  i_stall,
	input  decode_pkg::word_t     i_opr1,
	input  decode_pkg::word_t     i_opr2,
	input  decode_pkg::word_t     i_linkaddr,
	decode_ctrl_if.sink           ctrl,
	output decode_pkg::alu_op_t   o_aluop,
	output decode_pkg::alu_sel_t  o_alusel,
	output decode_pkg::word_t     o_opr1,
	output decode_pkg::word_t     o_opr2,
	output logic                  o_wreg,
	output decode_pkg::reg_addr_t o_wraddr,
	output decode_pkg::word_t     o_linkaddr
);
	import decode_pkg::*;

	always_ff @(posedge clk) begin
		if (rst || i_stall) begin  // bubble
			o_aluop    <= ALU_NOP;
			o_alusel   <= SEL_NOP;
			o_opr1     <= '0;
			o_opr2     <= '0;
			o_wreg     <= 1'b0;
			o_wraddr   <= '0;
			o_linkaddr <= '0;
		end else begin
			o_aluop    <= ctrl.aluop;
			o_alusel   <= ctrl.alusel;
			o_opr1     <= i_opr1;
			o_opr2     <= i_opr2;
			o_wreg     <= ctrl.wreg;
			o_wraddr   <= ctrl.wraddr;
			o_linkaddr <= i_linkaddr;
		end
	end

endmodule

//--- verilog/mips_decode_stage.sv
module mips_decode_stage (
	input  logic                  clk,
	input  logic                  rst,
	input  decode_pkg::word_t     i_pc,
	input  decode_pkg::inst_t     i_inst,
	input  decode_pkg::word_t     i_r1data,
	input  decode_pkg::word_t     i_r2data,
	output logic                  o_r1read,
	output logic                  o_r2read,
	output decode_pkg::reg_addr_t o_r1addr,
	output decode_pkg::reg_addr_t o_r2addr,
	input  decode_pkg::alu_op_t   i_ex_aluop,
	input  logic                  i_ex_wreg,
	input  decode_pkg::reg_addr_t i_ex_wraddr,
	input  decode_pkg::word_t     i_ex_wrdata,
	input  decode_pkg::alu_op_t   i_mem_aluop,
	input  logic                  i_mem_wreg,
	input  decode_pkg::reg_addr_t i_mem_wraddr,
	input  decode_pkg::word_t     i_mem_wrdata,
	output logic                  o_bflag,
	output decode_pkg::word_t     o_baddr,
	output logic                  o_stall,
	output decode_pkg::alu_op_t   o_aluop,
	output decode_pkg::alu_sel_t  o_alusel,
	output decode_pkg::word_t     o_opr1,
	output decode_pkg::word_t     o_opr2,
	output logic                  o_wreg,
	output decode_pkg::reg_addr_t o_wraddr,
	output decode_pkg::word_t     o_linkaddr
);
	import decode_pkg::*;

	word_t id_pc, opr1, opr2, linkaddr;
	inst_t id_inst;

	decode_ctrl_if ctrl ();
	fwd_src_if     ex_src ();
	fwd_src_if     mem_src ();

	assign ex_src.aluop   = i_ex_aluop;
	assign ex_src.wreg    = i_ex_wreg;
	assign ex_src.wraddr  = i_ex_wraddr;
	assign ex_src.wrdata  = i_ex_wrdata;
	assign mem_src.aluop  = i_mem_aluop;
	assign mem_src.wreg   = i_mem_wreg;
	assign mem_src.wraddr = i_mem_wraddr;
	assign mem_src.wrdata = i_mem_wrdata;

	if_id_reg u_if_id (.clk, .rst, .i_stall(o_stall), .i_pc, .i_inst, .o_pc(id_pc), .o_inst(id_inst));

	inst_decoder u_dec (.i_inst(id_inst), .ctrl(ctrl.dec));

	operand_forward u_fwd (.i_r1data, .i_r2data, .ctrl(ctrl.sink), .ex(ex_src.sink),
		.mem(mem_src.sink), .o_r1read, .o_r2read, .o_r1addr, .o_r2addr,
		.o_opr1(opr1), .o_opr2(opr2), .o_stall);

	branch_resolve u_br (.i_pc(id_pc), .i_inst(id_inst), .i_opr1(opr1), .i_opr2(opr2),
		.ctrl(ctrl.sink), .o_bflag, .o_baddr, .o_linkaddr(linkaddr));

	id_ex_reg u_id_ex (.clk, .rst, .i_stall(o_stall), .i_opr1(opr1), .i_opr2(opr2),
		.i_linkaddr(linkaddr), .ctrl(ctrl.sink), .o_aluop, .o_alusel, .o_opr1, .o_opr2,
		.o_wreg, .o_wraddr, .o_linkaddr);

endmodule

//--- sim/decode_vectors.svh
// One row per test with instruction, pc, EX and MEM forwarding, then expected op, class,
// write enable, destination, branch flag, stall, operand 1 and 2 sources, target rule and link
task automatic load_table();
	add_row(itype(OP_ORI, 1, 2, 16'h8001), 32'h0000_1000, NO_FWD, NO_FWD,
		ALU_OR, SEL_LOGIC, 1, 2, 0, 0, SRC_RS, SRC_ZE, TGT_NONE, 0);
	add_row(itype(OP_LUI, 0, 3, 16'habcd), 32'h0000_1004, NO_FWD, NO_FWD,
		ALU_OR, SEL_LOGIC, 1, 3, 0, 0, SRC_RS, SRC_UP, TGT_NONE, 0);
	add_row(itype(OP_ADDI, 5, 4, 16'hfffd), 32'h0000_1008, NO_FWD, NO_FWD,
		ALU_ADD, SEL_ARITH, 1, 4, 0, 0, SRC_RS, SRC_SE, TGT_NONE, 0);
	// EX and MEM both write r9
	add_row(rtype(9, 10, 8, 0, FN_SUB), 32'h0000_100c, fw(ALU_ADD, 1, 9, 32'h1111_1111),
		fw(ALU_OR, 1, 9, 32'h2222_2222), ALU_SUB, SEL_ARITH, 1, 8, 0, 0,
		SRC_RS, SRC_RT, TGT_NONE, 0);
	add_row(rtype(12, 13, 11, 0, FN_NOR), 32'h0000_1010, fw(ALU_ADD, 0, 12, 32'h3333_3333),
		fw(ALU_AND, 1, 13, 32'h4444_4444), ALU_NOR, SEL_LOGIC, 1, 11, 0, 0,
		SRC_RS, SRC_RT, TGT_NONE, 0);
	add_row(rtype(0, 15, 14, 7, FN_SRA), 32'h0000_1014, NO_FWD, NO_FWD,
		ALU_SRA, SEL_SHIFT, 1, 14, 0, 0, SRC_SA, SRC_RT, TGT_NONE, 0);
	// Load-use, EX then MEM
	add_row(rtype(20, 21, 19, 0, FN_ADDU), 32'h0000_1018, fw(ALU_LW, 1, 20, 32'h5555_5555),
		NO_FWD, ALU_ADDU, SEL_ARITH, 1, 19, 0, 1, SRC_RS, SRC_RT, TGT_NONE, 0);
	add_row(rtype(23, 24, 22, 0, FN_XOR), 32'h0000_101c, NO_FWD,
		fw(ALU_LBU, 1, 24, 32'h6666_6666), ALU_XOR, SEL_LOGIC, 1, 22, 0, 1,
		SRC_RS, SRC_RT, TGT_NONE, 0);
	add_row(itype(OP_LW, 26, 25, 16'hfff8), 32'h0000_1020, NO_FWD, NO_FWD,
		ALU_LW, SEL_LS, 1, 25, 0, 0, SRC_RS, SRC_SE, TGT_NONE, 0);
	add_row(itype(OP_SH, 28, 27, 16'h0006), 32'h0000_1024, NO_FWD, NO_FWD,
		ALU_SH, SEL_LS, 0, 0, 0, 0, SRC_RS, SRC_RT, TGT_NONE, 0);
	add_row(32'h7000_0020, 32'h0000_1028, NO_FWD, NO_FWD,  // CLZ is not decoded
		ALU_NOP, SEL_NOP, 0, 0, 0, 0, SRC_ZERO, SRC_ZERO, TGT_NONE, 0);
	add_row(itype(OP_BEQ, 3, 3, 16'hfffc), 32'h0000_2000, NO_FWD, NO_FWD,
		ALU_BEQ, SEL_JB, 0, 0, 1, 0, SRC_RS, SRC_RT, TGT_REL, 0);
	add_row(itype(OP_BNE, 3, 3, 16'h0010), 32'h0000_2004, NO_FWD, NO_FWD,
		ALU_BNE, SEL_JB, 0, 0, 0, 0, SRC_RS, SRC_RT, TGT_REL, 0);
	add_row(itype(OP_BGTZ, 5, 0, 16'h0008), 32'h0000_2008, fw(ALU_ADDU, 1, 5, 32'h0000_0040),
		NO_FWD, ALU_BGTZ, SEL_JB, 0, 0, 1, 0, SRC_RS, SRC_ZERO, TGT_REL, 0);
	add_row(itype(OP_BLEZ, 6, 0, 16'h0004), 32'h0000_200c, NO_FWD,
		fw(ALU_OR, 1, 6, 32'h0000_0001), ALU_BLEZ, SEL_JB, 0, 0, 0, 0,
		SRC_RS, SRC_ZERO, TGT_REL, 0);
	add_row(itype(OP_REGIMM, 7, RT_BLTZAL, 16'h0020), 32'h0000_2010, NO_FWD,
		fw(ALU_OR, 1, 7, 32'h8000_0000), ALU_BLTZAL, SEL_JB, 1, 31, 1, 0,
		SRC_RS, SRC_ZERO, TGT_REL, 1);
	add_row(itype(OP_REGIMM, 0, RT_BGEZ, 16'hffff), 32'h0000_2014, NO_FWD, NO_FWD,
		ALU_BGEZ, SEL_JB, 0, 0, 1, 0, SRC_RS, SRC_ZERO, TGT_REL, 0);
	add_row(jtype(OP_J, 26'h012_3456), 32'h3000_0100, NO_FWD, NO_FWD,
		ALU_J, SEL_JB, 0, 0, 1, 0, SRC_ZERO, SRC_ZERO, TGT_IDX, 0);
	add_row(jtype(OP_JAL, 26'h3ff_fffc), 32'h4000_0ff0, NO_FWD, NO_FWD,
		ALU_JAL, SEL_JB, 1, 31, 1, 0, SRC_ZERO, SRC_ZERO, TGT_IDX, 1);
	add_row(rtype(5, 0, 0, 0, FN_JR), 32'h0000_3000, NO_FWD, NO_FWD,
		ALU_JR, SEL_JB, 0, 0, 1, 0, SRC_RS, SRC_ZERO, TGT_REG, 0);
	add_row(rtype(8, 0, 7, 0, FN_JALR), 32'h0000_3004, fw(ALU_ADDU, 1, 8, 32'h0000_5a5c),
		NO_FWD, ALU_JALR, SEL_JB, 1, 7, 1, 0, SRC_RS, SRC_ZERO, TGT_REG, 1);
endtask

//--- sim/tb_mips_decode_stage.sv
module tb_mips_decode_stage;
	import decode_pkg::*;

	localparam int NUM_ROWS = 21;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 4 + 10 + 50;
	localparam logic [31:0] SEED = 32'hf660_ea58;

	// Operand sources and target rules
	localparam int SRC_ZERO = 0, SRC_RS = 1, SRC_RT = 2, SRC_ZE = 3;
	localparam int SRC_SE = 4, SRC_UP = 5, SRC_SA = 6;
	localparam int TGT_NONE = 0, TGT_REL = 1, TGT_IDX = 2, TGT_REG = 3;

	typedef struct packed {
		alu_op_t   op;
		logic      we;
		reg_addr_t wa;
		word_t     data;
	} fwd_t;

	typedef struct packed {
		inst_t      inst;
		word_t      pc;
		fwd_t       ex;
		fwd_t       mem;
		alu_op_t    op;
		alu_sel_t   sel;
		logic       we;
		reg_addr_t  wa;
		logic       bflag;
		logic       stall;
		logic [2:0] src1;
		logic [2:0] src2;
		logic [1:0] tgt;
		logic       link;
	} vec_t;

	localparam fwd_t NO_FWD = '0;

	logic      clk, rst;
	word_t     i_pc, i_r1data, i_r2data, i_ex_wrdata, i_mem_wrdata;
	inst_t     i_inst;
	alu_op_t   i_ex_aluop, i_mem_aluop, o_aluop;
	logic      i_ex_wreg, i_mem_wreg;
	reg_addr_t i_ex_wraddr, i_mem_wraddr, o_r1addr, o_r2addr, o_wraddr;
	logic      o_r1read, o_r2read, o_bflag, o_stall, o_wreg;
	word_t     o_baddr, o_opr1, o_opr2, o_linkaddr;
	alu_sel_t  o_alusel;

	vec_t  rows [NUM_ROWS];
	word_t rf [32];  // Register-file model
	fwd_t  cur_ex, cur_mem;
	int    n_rows, row_errs, n_pass, n_fail, cycles;

	mips_decode_stage i_mips_decode_stage (.*);

	assign i_r1data = rf[o_r1addr];
	assign i_r2data = rf[o_r2addr];
	assign {i_ex_aluop, i_ex_wreg, i_ex_wraddr, i_ex_wrdata} = cur_ex;
	assign {i_mem_aluop, i_mem_wreg, i_mem_wraddr, i_mem_wrdata} = cur_mem;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	function automatic inst_t itype(input opcode_t op, input int rs, input int rt, input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic inst_t rtype(input int rs, input int rt, input int rd, input int sa,
			input funct_t fn);
		return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn};
	endfunction

	function automatic inst_t jtype(input opcode_t op, input int idx);
		return {op, idx[25:0]};
	endfunction

	function automatic fwd_t fw(input alu_op_t op, input int we, input int wa, input word_t data);
		return {op, we[0], wa[4:0], data};
	endfunction

	task automatic add_row(input inst_t inst, input word_t pc, input fwd_t ex, input fwd_t mem,
			input alu_op_t op, input alu_sel_t sel, input int we, input int wa, input int bflag,
			input int stall, input int src1, input int src2, input int tgt, input int link);
		rows[n_rows] = {inst, pc, ex, mem, op, sel, we[0], wa[4:0], bflag[0], stall[0],
			src1[2:0], src2[2:0], tgt[1:0], link[0]};
		n_rows++;
	endtask

	`include "decode_vectors.svh"

	// Youngest writer wins, then the register file
	function automatic word_t fwd_value(input reg_addr_t addr);
		if (cur_ex.we && cur_ex.wa == addr)
			return cur_ex.data;
		if (cur_mem.we && cur_mem.wa == addr)
			return cur_mem.data;
		return rf[addr];
	endfunction

	function automatic word_t expected_operand(input logic [2:0] src, input inst_t inst);
		case (src)
			SRC_RS:  return fwd_value(inst[25:21]);
			SRC_RT:  return fwd_value(inst[20:16]);
			SRC_ZE:  return {16'h0000, inst[15:0]};
			SRC_SE:  return {{16{inst[15]}}, inst[15:0]};
			SRC_UP:  return {inst[15:0], 16'h0000};
			SRC_SA:  return {27'd0, inst[10:6]};
			default: return '0;
		endcase
	endfunction

	function automatic word_t expected_target(input vec_t v, input word_t opr1);
		word_t pc4;
		pc4 = v.pc + INST_BYTES;
		case (v.tgt)
			TGT_REL: return pc4 + 4 * {{16{v.inst[15]}}, v.inst[15:0]};
			TGT_IDX: return {pc4[31:28], v.inst[25:0], 2'b00};
			TGT_REG: return opr1;
			default: return '0;
		endcase
	endfunction

	task automatic mismatch(input string what, input word_t got, input word_t exp);
		$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
		row_errs++;
	endtask

	task automatic check_idle(input string when);
		if (o_wreg !== 1'b0 || o_bflag !== 1'b0 || o_stall !== 1'b0 || o_aluop !== ALU_NOP) begin
			$display("MISMATCH at %0t: outputs not idle %s", $time, when);
			row_errs++;
		end
	endtask

	task automatic report_test(input string name);
		if (row_errs == 0) begin
			n_pass++;
			$display("%s: pass", name);
		end else begin
			n_fail++;
			$display("%s: FAIL with %0d errors", name, row_errs);
		end
	endtask

	initial begin
		vec_t  v;
		word_t opr1_exp, opr2_exp, link_exp;
		logic  rd1_exp, rd2_exp;
		rst = 1'b1;
		i_pc = '0;
		i_inst = '0;
		cur_ex = NO_FWD;
		cur_mem = NO_FWD;
		{n_rows, row_errs, n_pass, n_fail, cycles} = '0;
		void'($urandom(SEED));
		rf[0] = '0;
		for (int r = 1; r < 32; r++)
			rf[r] = $urandom();
		load_table();

		repeat (3) @(negedge clk);
		check_idle("during reset");
		repeat (7) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_idle("after reset");
		report_test("reset");

		for (int i = 0; i < n_rows; i++) begin
			v = rows[i];
			row_errs = 0;
			@(negedge clk);
			i_inst = v.inst;
			i_pc = v.pc;
			cur_ex = NO_FWD;
			cur_mem = NO_FWD;
			@(negedge clk);  // Instruction now in IF/ID
			i_inst = '0;  // Fetch moves on to a nop
			i_pc = '0;
			cur_ex = v.ex;
			cur_mem = v.mem;
			#5;
			opr1_exp = expected_operand(v.src1, v.inst);
			rd1_exp = v.src1 == SRC_RS || v.src1 == SRC_RT;
			rd2_exp = v.src2 == SRC_RS || v.src2 == SRC_RT;
			if (o_stall !== v.stall)
				mismatch("o_stall", word_t'(o_stall), word_t'(v.stall));
			if (o_bflag !== v.bflag)
				mismatch("o_bflag", word_t'(o_bflag), word_t'(v.bflag));
			if (o_baddr !== (v.bflag ? expected_target(v, opr1_exp) : '0))
				mismatch("o_baddr", o_baddr, v.bflag ? expected_target(v, opr1_exp) : '0);
			if (o_r1read !== rd1_exp)
				mismatch("o_r1read", word_t'(o_r1read), word_t'(rd1_exp));
			if (o_r2read !== rd2_exp)
				mismatch("o_r2read", word_t'(o_r2read), word_t'(rd2_exp));
			if (rd1_exp && o_r1addr !== v.inst[25:21])
				mismatch("o_r1addr", word_t'(o_r1addr), word_t'(v.inst[25:21]));
			if (rd2_exp && o_r2addr !== v.inst[20:16])
				mismatch("o_r2addr", word_t'(o_r2addr), word_t'(v.inst[20:16]));
			if (v.stall) begin
				@(negedge clk);
				cur_ex = NO_FWD;  // Load has moved on
				cur_mem = NO_FWD;
				#5;
				if (o_aluop !== ALU_NOP || o_alusel !== SEL_NOP || o_wreg !== 1'b0
						|| o_opr1 !== '0 || o_opr2 !== '0 || o_linkaddr !== '0) begin
					$display("MISMATCH at %0t: ID/EX holds no bubble during stall", $time);
					row_errs++;
				end
			end
			opr1_exp = expected_operand(v.src1, v.inst);
			opr2_exp = expected_operand(v.src2, v.inst);
			link_exp = v.link ? v.pc + 2 * INST_BYTES : '0;
			@(negedge clk);
			#5;
			if (o_aluop !== v.op)
				mismatch("o_aluop", word_t'(o_aluop), word_t'(v.op));
			if (o_alusel !== v.sel)
				mismatch("o_alusel", word_t'(o_alusel), word_t'(v.sel));
			if (o_wreg !== v.we)
				mismatch("o_wreg", word_t'(o_wreg), word_t'(v.we));
			if (v.we && o_wraddr !== v.wa)
				mismatch("o_wraddr", word_t'(o_wraddr), word_t'(v.wa));
			if (o_opr1 !== opr1_exp)
				mismatch("o_opr1", o_opr1, opr1_exp);
			if (o_opr2 !== opr2_exp)
				mismatch("o_opr2", o_opr2, opr2_exp);
			if (o_linkaddr !== link_exp)
				mismatch("o_linkaddr", o_linkaddr, link_exp);
			report_test($sformatf("row %0d", i));
		end

		$display("%0d tests: %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- mips_decode_stage.f
+incdir+sim
verilog/decode_pkg.sv
verilog/stage_ifs.sv
verilog/if_id_reg.sv
verilog/inst_decoder.sv
verilog/operand_forward.sv
verilog/branch_resolve.sv
verilog/id_ex_reg.sv
verilog/mips_decode_stage.sv
sim/tb_mips_decode_stage.sv

//--- Bender.yml
package:
  name: mips_decode_stage

sources:
  - files:
      - verilog/decode_pkg.sv
      - verilog/stage_ifs.sv
      - verilog/if_id_reg.sv
      - verilog/inst_decoder.sv
      - verilog/operand_forward.sv
      - verilog/branch_resolve.sv
      - verilog/id_ex_reg.sv
      - verilog/mips_decode_stage.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mips_decode_stage.sv
